//--- aligned_ram.sv
`default_nettype none

module aligned_ram #(
    parameter int DIN_WIDTH = 32,
    parameter int N_DIN_TO_DOUT = 1,
    parameter int DOUT_ADDR_WIDTH = 10,
    localparam int WADDR_WIDTH = DOUT_ADDR_WIDTH + $clog2(N_DIN_TO_DOUT),
    localparam int DOUT_WIDTH = DIN_WIDTH * N_DIN_TO_DOUT
) (
    input  logic                       clk,
    input  logic [DIN_WIDTH-1:0]       write_data,
    input  logic [WADDR_WIDTH-1:0]     write_addr,
    input  logic                       write_enable,
    input  logic [DOUT_ADDR_WIDTH-1:0] read_addr,
    output logic [DOUT_WIDTH-1:0]      read_data
);

    // narrow words, one wide word spans N_DIN_TO_DOUT neighbours
    logic [DIN_WIDTH-1:0] mem [N_DIN_TO_DOUT << DOUT_ADDR_WIDTH];
    logic [DOUT_ADDR_WIDTH-1:0] read_addr_q;

    always_ff @(posedge clk) begin
        if (write_enable) begin
            mem[write_addr] <= write_data;
        end
    end

    // ####################
    // read side, address reg then output reg

    always_ff @(posedge clk) begin
        read_addr_q <= read_addr;
        for (int lane = 0; lane < N_DIN_TO_DOUT; lane++) begin
            // lowest narrow address lands in the lowest lane
            read_data[lane*DIN_WIDTH +: DIN_WIDTH] <=
                mem[WADDR_WIDTH'(read_addr_q * N_DIN_TO_DOUT + lane)];
        end
    end

endmodule

`default_nettype wire

//--- axil_pkg.sv
`default_nettype none

package axil_pkg;

    localparam int AXIL_ADDR_WIDTH = 32;
    localparam int AXIL_DATA_WIDTH = 32;

    // address map
    localparam int ADDR_CORE_LSB = 15;
    localparam int ADDR_MEM_LSB = 12;
    localparam int ADDR_WORD_LSB = 2;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axil_resp_e;

    typedef struct packed {
        logic [AXIL_ADDR_WIDTH-1:0] addr;
        logic                       valid;
    } axil_aw_t;

    typedef struct packed {
        logic [AXIL_DATA_WIDTH-1:0]   data;
        logic [AXIL_DATA_WIDTH/8-1:0] strb;
        logic                         valid;
    } axil_w_t;

    typedef struct packed {
        axil_resp_e resp;
        logic       valid;
    } axil_b_t;

    typedef struct packed {
        logic [AXIL_ADDR_WIDTH-1:0] addr;
        logic                       valid;
    } axil_ar_t;

    typedef struct packed {
        logic [AXIL_DATA_WIDTH-1:0] data;
        axil_resp_e                 resp;
        logic                       valid;
    } axil_r_t;

endpackage

`default_nettype wire

//--- dac_combiner.sv
`default_nettype none

module dac_combiner (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic signed [dsp_pkg::SAMPLE_WIDTH-1:0] samples [dsp_pkg::NCORE],
    input  logic [dsp_pkg::NCORE-1:0]               busy,
    output logic signed [dsp_pkg::SAMPLE_WIDTH-1:0] dac,
    output logic                                    dac_valid
);

    import dsp_pkg::*;

    logic signed [SUM_WIDTH-1:0]    sum;
    logic signed [SAMPLE_WIDTH-1:0] clamped;

    // widened so the sum cannot wrap
    always_comb begin
        sum = '0;
        for (int i = 0; i < NCORE; i++) begin
            sum = sum + SUM_WIDTH'(samples[i]);
        end
    end

    always_comb begin
        if (sum > SAMPLE_MAX) begin
            clamped = SAMPLE_WIDTH'(SAMPLE_MAX);
        end else if (sum < SAMPLE_MIN) begin
            clamped = SAMPLE_WIDTH'(SAMPLE_MIN);
        end else begin
            clamped = sum[SAMPLE_WIDTH-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dac <= '0;
            dac_valid <= 1'b0;
        end else begin
            dac <= clamped;
            dac_valid <= |busy;
        end
    end

endmodule

`default_nettype wire

//--- dsp_pkg.sv
`default_nettype none

package dsp_pkg;

    localparam int NCORE = 3;
    localparam int SEL_WIDTH = 3;

    // sample path
    localparam int SAMPLE_WIDTH = 16;
    localparam int SUM_WIDTH = SAMPLE_WIDTH + $clog2(NCORE);
    localparam int SAMPLE_MAX = 2 ** (SAMPLE_WIDTH - 1) - 1;
    localparam int SAMPLE_MIN = -(2 ** (SAMPLE_WIDTH - 1));

    // memory geometry
    localparam int HOST_WORD_WIDTH = 32;
    localparam int CMD_WORDS = 2;
    localparam int CMD_ADDRWIDTH = 6;
    localparam int CMD_W_ADDRWIDTH = CMD_ADDRWIDTH + $clog2(CMD_WORDS);
    localparam int ENV_ADDRWIDTH = 10;
    localparam int LENGTH_WIDTH = 10;

    // zero-output cycles spent on every command
    localparam int FETCH_CYCLES = 3;
    localparam int FETCH_CNT_WIDTH = $clog2(FETCH_CYCLES);

    typedef enum logic [1:0] {
        OP_PLAY = 2'd0,
        OP_WAIT = 2'd1,
        OP_END  = 2'd2
    } opcode_e;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_FETCH,
        ST_PLAY,
        ST_WAIT
    } core_state_e;

    typedef enum logic [SEL_WIDTH-1:0] {
        MEM_CMD = 3'd0,
        MEM_ENV = 3'd1
    } mem_sel_e;

    // upper host word first, lower word in bits 31:0
    typedef struct packed {
        logic [15:0]                    reserved_hi;
        logic signed [SAMPLE_WIDTH-1:0] amplitude;
        opcode_e                        opcode;
        logic [9:0]                     reserved_lo;
        logic [ENV_ADDRWIDTH-1:0]       env_addr;
        logic [LENGTH_WIDTH-1:0]        length;
    } command_t;

    typedef struct packed {
        logic [SEL_WIDTH-1:0]       core;
        mem_sel_e                   mem;
        logic [ENV_ADDRWIDTH-1:0]   addr;
        logic [HOST_WORD_WIDTH-1:0] data;
        logic                       en;
    } host_wr_t;

endpackage

`default_nettype wire

//--- dsp_tb.sv
`default_nettype none

module dsp_tb;

    import dsp_pkg::*;
    import axil_pkg::*;

    localparam int CLK_PERIOD = 8;
    localparam int RESET_CYCLES = 8;
    // doubled upper bounds on host writes and runs
    localparam int N_WRITES = 200;
    localparam int WRITE_CYCLES = 3;
    localparam int N_RUNS = 6;
    localparam int RUN_CYCLES = 64;
    localparam int TIMEOUT_CYCLES =
        2 * (RESET_CYCLES + N_WRITES * WRITE_CYCLES + N_RUNS * RUN_CYCLES);

    logic                           clk;
    logic                           rst;
    logic                           stb_start;
    axil_aw_t                       aw;
    axil_w_t                        w;
    logic                           awready;
    logic                           wready;
    axil_b_t                        b;
    logic                           bready;
    axil_ar_t                       ar;
    logic                           arready;
    axil_r_t                        r;
    logic                           rready;
    logic signed [SAMPLE_WIDTH-1:0] dac;
    logic                           dac_valid;

    integer seed = 32'h8022_48b3;

    // model copies of what the host wrote
    command_t                       cmd_model [NCORE][2**CMD_ADDRWIDTH];
    logic [SAMPLE_WIDTH-1:0]        env_model [NCORE][2**ENV_ADDRWIDTH];
    logic signed [SAMPLE_WIDTH-1:0] core_seq [NCORE][1024];
    int                             core_len [NCORE];
    logic signed [SAMPLE_WIDTH-1:0] expected_dac [$];
    int                             pos_clamps;
    int                             neg_clamps;

    tb_clock #(.PERIOD(CLK_PERIOD)) u_clock (.clk(clk));

    dsp_top uut (
        .clk(clk),
        .rst(rst),
        .stb_start(stb_start),
        .aw(aw),
        .w(w),
        .awready(awready),
        .wready(wready),
        .b(b),
        .bready(bready),
        .ar(ar),
        .arready(arready),
        .r(r),
        .rready(rready),
        .dac(dac),
        .dac_valid(dac_valid)
    );

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Error: %s is %h, expected %h", name, actual, expected);
            $display("** FAIL **");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // ####################
    // host bus

    function automatic logic [31:0] host_addr(input int core, input int mem, input int word);
        return (core << ADDR_CORE_LSB) | (mem << ADDR_MEM_LSB) | (word << ADDR_WORD_LSB);
    endfunction

    task automatic wait_write_accept();
        #1;
        while (!(awready && wready)) begin
            @(negedge clk);
            #1;
        end
        // transfer on the coming rising edge
        @(negedge clk);
        aw.valid = 1'b0;
        w.valid = 1'b0;
    endtask

    task automatic axil_write(input logic [31:0] addr, input logic [31:0] data,
                              input axil_resp_e exp_resp);
        @(negedge clk);
        aw.addr = addr;
        aw.valid = 1'b1;
        w.data = data;
        w.strb = 4'hf;
        w.valid = 1'b1;
        wait_write_accept();
        check_value("bvalid", b.valid, 1);
        check_value("bresp", b.resp, exp_resp);
    endtask

    task automatic axil_read(input logic [31:0] addr, input logic [31:0] exp_data,
                             input axil_resp_e exp_resp);
        @(negedge clk);
        ar.addr = addr;
        ar.valid = 1'b1;
        #1;
        while (!arready) begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        ar.valid = 1'b0;
        check_value("rvalid", r.valid, 1);
        check_value("rdata", r.data, exp_data);
        check_value("rresp", r.resp, exp_resp);
    endtask

    task automatic write_env(input int core, input int addr, input logic [31:0] word);
        env_model[core][addr] = word[SAMPLE_WIDTH-1:0];
        axil_write(host_addr(core, MEM_ENV, addr), word, RESP_OKAY);
    endtask

    task automatic fill_env_random(input int core, input int count);
        logic [31:0] word;
        for (int i = 0; i < count; i++) begin
            word = $random(seed);
            write_env(core, i, word);
        end
    endtask

    task automatic write_cmd(input int core, input int idx, input opcode_e op,
                             input int amp, input int env_addr, input int length);
        command_t cmd;
        cmd = '0;
        cmd.amplitude = amp[SAMPLE_WIDTH-1:0];
        cmd.opcode = op;
        cmd.env_addr = env_addr[ENV_ADDRWIDTH-1:0];
        cmd.length = length[LENGTH_WIDTH-1:0];
        cmd_model[core][idx] = cmd;
        // lower word at the even address
        axil_write(host_addr(core, MEM_CMD, 2 * idx), cmd[31:0], RESP_OKAY);
        axil_write(host_addr(core, MEM_CMD, 2 * idx + 1), cmd[63:32], RESP_OKAY);
    endtask

    // ####################
    // reference model

    task automatic model_core(input int c);
        command_t                         cmd;
        int                               pc;
        int                               n;
        bit                               done;
        logic signed [2*SAMPLE_WIDTH-1:0] product;
        logic signed [2*SAMPLE_WIDTH-1:0] shifted;
        pc = 0;
        n = 0;
        done = 1'b0;
        while (!done) begin
            cmd = cmd_model[c][pc];
            pc++;
            for (int k = 0; k < FETCH_CYCLES; k++) begin
                core_seq[c][n] = '0;
                n++;
            end
            for (int k = 0; k < cmd.length && cmd.opcode != OP_END; k++) begin
                if (cmd.opcode == OP_PLAY) begin
                    product = $signed(env_model[c][(cmd.env_addr + k) % (2**ENV_ADDRWIDTH)])
                              * $signed(cmd.amplitude);
                    shifted = product >>> (SAMPLE_WIDTH - 1);
                    core_seq[c][n] = shifted[SAMPLE_WIDTH-1:0];
                end else begin
                    core_seq[c][n] = '0;
                end
                n++;
            end
            done = (cmd.opcode == OP_END);
        end
        core_len[c] = n;
    endtask

    task automatic build_expected();
        int total;
        int acc;
        total = 0;
        expected_dac.delete();
        for (int c = 0; c < NCORE; c++) begin
            model_core(c);
            total = (core_len[c] > total) ? core_len[c] : total;
        end
        for (int i = 0; i < total; i++) begin
            acc = 0;
            for (int c = 0; c < NCORE; c++) begin
                // finished cores add zero
                acc += (i < core_len[c]) ? int'(core_seq[c][i]) : 0;
            end
            acc = (acc > SAMPLE_MAX) ? SAMPLE_MAX : acc;
            acc = (acc < SAMPLE_MIN) ? SAMPLE_MIN : acc;
            expected_dac.push_back(acc[SAMPLE_WIDTH-1:0]);
        end
    endtask

    task automatic pulse_start();
        @(negedge clk);
        stb_start = 1'b1;
        @(negedge clk);
        stb_start = 1'b0;
    endtask

    task automatic run_and_check();
        int n;
        build_expected();
        pos_clamps = 0;
        neg_clamps = 0;
        pulse_start();
        // busy comes one cycle after the strobe and dac one more
        @(negedge clk);
        check_value("dac_valid", dac_valid, 1);
        n = 0;
        while (dac_valid) begin
            if (n >= expected_dac.size()) begin
                check_value("dac_valid", dac_valid, 0);
            end else begin
                check_value("dac", dac, expected_dac[n]);
            end
            pos_clamps += (dac == SAMPLE_MAX) ? 1 : 0;
            neg_clamps += (dac == SAMPLE_MIN) ? 1 : 0;
            n++;
            @(negedge clk);
        end
        check_value("dac sample count", n, expected_dac.size());
    endtask

    // ####################
    // tests

    task automatic after_reset_state();
        check_value("dac_valid", dac_valid, 0);
        check_value("bvalid", b.valid, 0);
        check_value("rvalid", r.valid, 0);
        check_value("awready", awready, 0);
        check_value("wready", wready, 0);
        check_value("arready", arready, 0);
        axil_read(32'h0, 32'h0, RESP_OKAY);
        axil_read(32'h4, 32'h0, RESP_SLVERR);
    endtask

    task automatic write_response_codes();
        for (int c = 0; c < NCORE; c++) begin
            write_cmd(c, 0, OP_END, 0, 0, 0);
        end
        write_env(0, 0, 32'h0000_1000);
        // a play word that would stretch the run if it landed
        axil_write(host_addr(NCORE, MEM_CMD, 0), 32'h0000_0005, RESP_SLVERR);
        axil_write(host_addr(1, 2, 0), 32'h0000_0005, RESP_SLVERR);
        run_and_check();
    endtask

    task automatic single_core_playback();
        fill_env_random(0, 24);
        write_cmd(0, 0, OP_PLAY, 32'h7fff, 0, 10);
        write_cmd(0, 1, OP_WAIT, 0, 0, 4);
        write_cmd(0, 2, OP_PLAY, 32'h7fff, 10, 14);
        write_cmd(0, 3, OP_END, 0, 0, 0);
        run_and_check();
    endtask

    task automatic all_core_mix();
        fill_env_random(1, 24);
        fill_env_random(2, 24);
        write_cmd(0, 0, OP_PLAY, -16384, 2, 6);
        write_cmd(0, 1, OP_WAIT, 0, 0, 5);
        write_cmd(0, 2, OP_PLAY, -32767, 0, 8);
        write_cmd(0, 3, OP_END, 0, 0, 0);
        write_cmd(1, 0, OP_WAIT, 0, 0, 3);
        write_cmd(1, 1, OP_PLAY, -8192, 0, 12);
        write_cmd(1, 2, OP_END, 0, 0, 0);
        write_cmd(2, 0, OP_PLAY, -24576, 4, 20);
        write_cmd(2, 1, OP_WAIT, 0, 0, 7);
        write_cmd(2, 2, OP_END, 0, 0, 0);
        run_and_check();
    endtask

    task automatic saturation_clamp();
        for (int c = 0; c < NCORE; c++) begin
            for (int i = 0; i < 8; i++) begin
                write_env(c, i, 32'h0000_7fff);
                write_env(c, i + 8, 32'h0000_8000);
            end
            write_cmd(c, 0, OP_PLAY, 32'h7fff, 0, 8);
            write_cmd(c, 1, OP_PLAY, 32'h7fff, 8, 8);
            write_cmd(c, 2, OP_END, 0, 0, 0);
        end
        run_and_check();
        check_value("positive clamp count", pos_clamps, 8);
        check_value("negative clamp count", neg_clamps, 8);
    endtask

    task automatic backpressure_and_status();
        bready = 1'b0;
        write_env(0, 900, 32'h0000_1234);
        // second write queued behind the held response
        aw.addr = host_addr(NCORE, MEM_ENV, 0);
        aw.valid = 1'b1;
        w.data = 32'h0000_5678;
        w.valid = 1'b1;
        repeat (4) begin
            @(negedge clk);
            check_value("bvalid", b.valid, 1);
            check_value("bresp", b.resp, RESP_OKAY);
            check_value("awready", awready, 0);
            check_value("wready", wready, 0);
        end
        bready = 1'b1;
        wait_write_accept();
        check_value("bvalid", b.valid, 1);
        check_value("bresp", b.resp, RESP_SLVERR);
        fork
            run_and_check();
            begin
                repeat (6) @(negedge clk);
                axil_read(32'h0, (1 << NCORE) - 1, RESP_OKAY);
                // ignored while the cores are busy
                pulse_start();
            end
        join
        axil_read(32'h0, 32'h0, RESP_OKAY);
    endtask

    initial begin
        rst = 1'b1;
        stb_start = 1'b0;
        aw = '0;
        w = '0;
        ar = '0;
        bready = 1'b1;
        rready = 1'b1;
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
        after_reset_state();
        write_response_codes();
        single_core_playback();
        all_core_mix();
        saturation_clamp();
        backpressure_and_status();
        $display("** PASS **");
        $finish;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("timeout: tests still running after %0d cycles", TIMEOUT_CYCLES);
        $display("** FAIL **");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

//--- dsp_top.sv
`default_nettype none

module dsp_top (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic                                    stb_start,
    input  axil_pkg::axil_aw_t                      aw,
    input  axil_pkg::axil_w_t                       w,
    output logic                                    awready,
    output logic                                    wready,
    output axil_pkg::axil_b_t                       b,
    input  logic                                    bready,
    input  axil_pkg::axil_ar_t                      ar,
    output logic                                    arready,
    output axil_pkg::axil_r_t                       r,
    input  logic                                    rready,
    output logic signed [dsp_pkg::SAMPLE_WIDTH-1:0] dac,
    output logic                                    dac_valid
);

    import dsp_pkg::*;

    host_wr_t                       host_wr;
    logic [NCORE-1:0]               core_busy;
    logic signed [SAMPLE_WIDTH-1:0] core_sample [NCORE];

    host_write_decoder u_decoder (
        .clk(clk),
        .rst(rst),
        .aw(aw),
        .w(w),
        .awready(awready),
        .wready(wready),
        .b(b),
        .bready(bready),
        .ar(ar),
        .arready(arready),
        .r(r),
        .rready(rready),
        .busy(core_busy),
        .host_wr(host_wr)
    );

    // every core sees every write and keeps its own
    for (genvar i = 0; i < NCORE; i++) begin : g_core
        pulse_core #(
            .CORE_INDEX(i)
        ) u_core (
            .clk(clk),
            .rst(rst),
            .stb_start(stb_start),
            .host_wr(host_wr),
            .sample(core_sample[i]),
            .busy(core_busy[i])
        );
    end

    dac_combiner u_combiner (
        .clk(clk),
        .rst(rst),
        .samples(core_sample),
        .busy(core_busy),
        .dac(dac),
        .dac_valid(dac_valid)
    );

endmodule

`default_nettype wire

//--- host_write_decoder.sv
`default_nettype none

module host_write_decoder (
    input  logic                        clk,
    input  logic                        rst,
    input  axil_pkg::axil_aw_t          aw,
    input  axil_pkg::axil_w_t           w,
    output logic                        awready,
    output logic                        wready,
    output axil_pkg::axil_b_t           b,
    input  logic                        bready,
    input  axil_pkg::axil_ar_t          ar,
    output logic                        arready,
    output axil_pkg::axil_r_t           r,
    input  logic                        rready,
    input  logic [dsp_pkg::NCORE-1:0]   busy,
    output dsp_pkg::host_wr_t           host_wr
);

    import axil_pkg::*;
    import dsp_pkg::*;

    logic [SEL_WIDTH-1:0] wr_core;
    logic [SEL_WIDTH-1:0] wr_mem;
    logic                 wr_in_range;
    logic                 wr_accept;
    logic                 rd_accept;

    // ####################
    // write channel

    assign wr_core = aw.addr[ADDR_CORE_LSB +: SEL_WIDTH];
    assign wr_mem  = aw.addr[ADDR_MEM_LSB +: SEL_WIDTH];

    assign wr_in_range = (wr_core < NCORE) && (wr_mem <= MEM_ENV);

    // aw and w taken as a pair, never while a response is pending
    assign wr_accept = aw.valid && w.valid && !b.valid;
    assign awready = wr_accept;
    assign wready = wr_accept;

    always_ff @(posedge clk) begin
        if (rst) begin
            b.valid <= 1'b0;
            host_wr.en <= 1'b0;
        end else begin
            // out of range writes still answer, but touch no memory
            host_wr.en <= wr_accept && wr_in_range;
            if (wr_accept) begin
                b.valid <= 1'b1;
                b.resp <= wr_in_range ? RESP_OKAY : RESP_SLVERR;
                host_wr.core <= wr_core;
                host_wr.mem <= mem_sel_e'(wr_mem);
                host_wr.addr <= aw.addr[ADDR_MEM_LSB-1:ADDR_WORD_LSB];
                // byte strobes ignored, full word stored
                host_wr.data <= w.data;
            end else if (bready) begin
                b.valid <= 1'b0;
            end
        end
    end

    // ####################
    // read channel, status only

    assign rd_accept = ar.valid && !r.valid;
    assign arready = rd_accept;

    always_ff @(posedge clk) begin
        if (rst) begin
            r.valid <= 1'b0;
        end else begin
            if (rd_accept) begin
                r.valid <= 1'b1;
                if (ar.addr == '0) begin
                    r.data <= AXIL_DATA_WIDTH'(busy);
                    r.resp <= RESP_OKAY;
                end else begin
                    r.data <= '0;
                    r.resp <= RESP_SLVERR;
                end
            end else if (rready) begin
                r.valid <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- pulse_core.sv
`default_nettype none

module pulse_core #(
    parameter int CORE_INDEX = 0
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                stb_start,
    input  dsp_pkg::host_wr_t                   host_wr,
    output logic signed [dsp_pkg::SAMPLE_WIDTH-1:0] sample,
    output logic                                busy
);

    import dsp_pkg::*;

    logic                           cmd_wen;
    logic                           env_wen;
    command_t                       cmd_rdata;
    logic [HOST_WORD_WIDTH-1:0]     env_rdata;

    core_state_e                    state;
    logic [FETCH_CNT_WIDTH-1:0]     fetch_cnt;
    logic                           cmd_latch;
    logic                           fetch_done;
    logic [CMD_ADDRWIDTH-1:0]       cmd_ptr;
    command_t                       cmd_q;
    logic [LENGTH_WIDTH-1:0]        len_cnt;
    logic [ENV_ADDRWIDTH-1:0]       env_ptr;

    logic signed [2*SAMPLE_WIDTH-1:0] product;
    logic signed [2*SAMPLE_WIDTH-1:0] scaled;

    // ####################
    // memories

    assign cmd_wen = host_wr.en && (host_wr.core == SEL_WIDTH'(CORE_INDEX))
                     && (host_wr.mem == MEM_CMD);
    assign env_wen = host_wr.en && (host_wr.core == SEL_WIDTH'(CORE_INDEX))
                     && (host_wr.mem == MEM_ENV);

    aligned_ram #(
        .DIN_WIDTH(HOST_WORD_WIDTH),
        .N_DIN_TO_DOUT(CMD_WORDS),
        .DOUT_ADDR_WIDTH(CMD_ADDRWIDTH)
    ) cmd_mem (
        .clk(clk),
        .write_data(host_wr.data),
        .write_addr(host_wr.addr[CMD_W_ADDRWIDTH-1:0]),
        .write_enable(cmd_wen),
        .read_addr(cmd_ptr),
        .read_data(cmd_rdata)
    );

    aligned_ram #(
        .DIN_WIDTH(HOST_WORD_WIDTH),
        .N_DIN_TO_DOUT(1),
        .DOUT_ADDR_WIDTH(ENV_ADDRWIDTH)
    ) env_mem (
        .clk(clk),
        .write_data(host_wr.data),
        .write_addr(host_wr.addr),
        .write_enable(env_wen),
        .read_addr(env_ptr),
        .read_data(env_rdata)
    );

    // ####################
    // sequencer

    // cmd_ptr already points at this command, so its word is ready in fetch 0
    assign cmd_latch = (state == ST_FETCH) && (fetch_cnt == '0);
    assign fetch_done = (state == ST_FETCH)
                        && (fetch_cnt == FETCH_CNT_WIDTH'(FETCH_CYCLES - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
            fetch_cnt <= '0;
            cmd_ptr <= '0;
            len_cnt <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    fetch_cnt <= '0;
                    if (stb_start) begin
                        state <= ST_FETCH;
                    end
                end
                ST_FETCH: begin
                    fetch_cnt <= fetch_cnt + 1'b1;
                    if (cmd_latch) begin
                        // prefetch next command, or rewind early for the next run
                        if (cmd_rdata.opcode == OP_PLAY || cmd_rdata.opcode == OP_WAIT) begin
                            cmd_ptr <= cmd_ptr + 1'b1;
                        end else begin
                            cmd_ptr <= '0;
                        end
                    end
                    if (fetch_done) begin
                        fetch_cnt <= '0;
                        len_cnt <= cmd_q.length - 1'b1;
                        case (cmd_q.opcode)
                            OP_PLAY: state <= (cmd_q.length == '0) ? ST_FETCH : ST_PLAY;
                            OP_WAIT: state <= (cmd_q.length == '0) ? ST_FETCH : ST_WAIT;
                            default: state <= ST_IDLE;
                        endcase
                    end
                end
                ST_PLAY, ST_WAIT: begin
                    len_cnt <= len_cnt - 1'b1;
                    if (len_cnt == '0) begin
                        state <= ST_FETCH;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // env address runs two cycles ahead of the sample it feeds
    always_ff @(posedge clk) begin
        env_ptr <= env_ptr + 1'b1;
        if (cmd_latch) begin
            cmd_q <= cmd_rdata;
            env_ptr <= cmd_rdata.env_addr;
        end
    end

    // ####################
    // scale

    assign product = $signed(env_rdata[SAMPLE_WIDTH-1:0]) * $signed(cmd_q.amplitude);
    assign scaled = product >>> (SAMPLE_WIDTH - 1);

    assign sample = (state == ST_PLAY) ? scaled[SAMPLE_WIDTH-1:0] : '0;
    assign busy = (state != ST_IDLE);

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# build with Verilator, then run; the exit status follows the simulation
verilator --binary --timing -Wno-fatal --top-module dsp_tb -f src.f \
    && ./obj_dir/Vdsp_tb \
    || exit 1

//--- src.f
dsp_pkg.sv
axil_pkg.sv
aligned_ram.sv
host_write_decoder.sv
pulse_core.sv
dac_combiner.sv
dsp_top.sv
tb_clock.sv
dsp_tb.sv

//--- tb_clock.sv
`default_nettype none

module tb_clock #(
    parameter int PERIOD = 8
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

endmodule

`default_nettype wire
